//--- common/readout_pkg.sv
package readout_pkg;

	// ========================================
	// sizes and packet layout
	// ========================================
	localparam int num_channels = 8;
	localparam int word_bits = 120;
	localparam int hit_bits = 116; // payload kept from a channel word
	localparam int level_bits = 10;
	localparam int slots_per_packet = 16;
	localparam int words_per_packet = 18; // header, 16 slots, levels
	localparam int header_bytes = 14; // trailing 0xff of the header is not sent
	localparam int slot_bytes = 15;
	localparam int level_bytes = 10; // the 40 filler ones are not sent
	localparam int packet_bytes = 264;
	localparam int bridge_depth = 32;

	// ========================================
	// vector types
	// ========================================
	typedef logic [word_bits-1:0] word_t;
	typedef logic [47:0] mac_t;
	typedef logic [11:0] period_t;
	typedef logic [level_bits-1:0] level_t;
	typedef logic [num_channels-1:0] chan_mask_t;
	typedef logic [2:0] chan_id_t;
	typedef logic [7:0] pkt_count_t;
	typedef logic [7:0] byte_t;
	typedef logic [5:0] fill_t; // 0 to bridge_depth

	localparam byte_t status_marker = 8'hF0; // empty slot

	// ========================================
	// port bundles and state machines
	// ========================================
	typedef struct packed {
		word_t data;
		level_t level;
		logic empty;
	} channel_in_t;

	typedef struct packed {
		mac_t dst_mac;
		mac_t src_mac;
	} mac_cfg_t;

	typedef enum logic [1:0] {
		idle,
		header,
		slot,
		levels
	} build_state_t;

	typedef enum logic {
		load,
		shift
	} ser_state_t;

endpackage

//--- verilog/frame_timer.sv
module frame_timer (
	input  logic clk,
	input  logic reset,
	input  readout_pkg::period_t frame_period,
	output logic frame_open
);
	import readout_pkg::*;

	period_t count;
	logic wrap;

	assign wrap = (count == frame_period);

	// one frame every frame_period + 1 cycles
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			frame_open <= 1'b0;
		end else begin
			if (wrap) begin
				count <= '0;
			end else begin
				count <= count + period_t'(1);
			end
			frame_open <= wrap; // single cycle strobe
		end
	end

endmodule

//--- collector/channel_scan.sv
module channel_scan (
	input  logic clk,
	input  logic reset,
	input  logic slot_active,
	input  logic scan_clear,
	input  readout_pkg::chan_mask_t not_empty,
	output readout_pkg::chan_mask_t channel_read,
	output readout_pkg::chan_id_t read_id
);
	import readout_pkg::*;

	chan_mask_t pending;
	chan_mask_t candidates;
	chan_mask_t pick;

	// reload from the live not-empty set once the mask runs dry
	always_comb begin
		candidates = (pending == '0) ? not_empty : pending;
	end

	// highest channel number wins
	always_comb begin
		pick = '0;
		read_id = '0;
		for (int i = 0; i < num_channels; i++) begin
			if (candidates[i]) begin
				pick = '0;
				pick[i] = 1'b1;
				read_id = chan_id_t'(i);
			end
		end
	end

	assign channel_read = slot_active ? pick : '0; // zero means empty slot

	always_ff @(posedge clk) begin
		if (reset || scan_clear) begin
			pending <= '0;
		end else if (slot_active) begin
			pending <= candidates & ~pick; // drop the channel just read
		end
	end

endmodule

//--- collector/packet_builder.sv
module packet_builder (
	input  logic clk,
	input  logic reset,
	input  logic frame_open,
	input  readout_pkg::fill_t fifo_free,
	input  readout_pkg::mac_cfg_t mac_cfg,
	input  readout_pkg::chan_mask_t channel_linked,
	input  readout_pkg::channel_in_t [readout_pkg::num_channels-1:0] channel_in,
	output readout_pkg::chan_mask_t channel_read,
	output readout_pkg::word_t wr_word,
	output logic wr_en
);
	import readout_pkg::*;

	build_state_t state;
	logic [3:0] slot_cnt; // slot on the write port
	pkt_count_t pkt_count;
	chan_mask_t not_empty;
	chan_id_t read_id;
	logic start;
	logic last_slot;
	logic slot_active;
	word_t hit_word;
	word_t level_word;

	// ========================================
	// word formats
	// ========================================
	always_comb begin
		level_word = '1; // low 40 bits stay ones
		for (int i = 0; i < num_channels; i++) begin
			not_empty[i] = ~channel_in[i].empty;
			level_word[word_bits - num_channels*level_bits + i*level_bits +: level_bits] =
				channel_in[i].level; // channel 7 ends up on top
		end
	end

	always_comb begin
		if (channel_read != '0) begin
			hit_word = {1'b1, read_id, channel_in[read_id].data[hit_bits-1:0]};
		end else begin
			hit_word = {{(word_bits-16){1'b0}}, status_marker, channel_linked};
		end
	end

	// ========================================
	// sequencer
	// ========================================
	// a whole packet must fit, otherwise the frame is skipped
	assign start = (state == idle) && frame_open && (fifo_free >= fill_t'(words_per_packet));
	assign last_slot = (slot_cnt == 4'(slots_per_packet - 1));

	// slots are built one cycle ahead of their write
	assign slot_active = (state == header) || ((state == slot) && !last_slot);

	channel_scan channel_scan_inst (
		.clk(clk),
		.reset(reset),
		.slot_active(slot_active),
		.scan_clear(start),
		.not_empty(not_empty),
		.channel_read(channel_read),
		.read_id(read_id)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			slot_cnt <= '0;
			pkt_count <= '0;
			wr_en <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (start) begin
						state <= header;
						pkt_count <= pkt_count + pkt_count_t'(1);
						wr_en <= 1'b1;
					end
				end
				header: begin
					state <= slot;
					slot_cnt <= '0;
				end
				slot: begin
					slot_cnt <= slot_cnt + 4'd1;
					if (last_slot) begin
						state <= levels;
					end
				end
				levels: begin
					state <= idle; // level word goes out this cycle
					wr_en <= 1'b0;
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			wr_word <= {mac_cfg.dst_mac, mac_cfg.src_mac, pkt_count, 8'h00, 8'hFF};
		end else if (slot_active) begin
			wr_word <= hit_word;
		end else if ((state == slot) && last_slot) begin
			wr_word <= level_word; // levels as seen now
		end
	end

endmodule

//--- verilog/bridge_fifo.sv
module bridge_fifo (
	input  logic clk,
	input  logic reset,
	input  readout_pkg::word_t wr_word,
	input  logic wr_en,
	input  logic pop,
	output readout_pkg::word_t rd_word,
	output logic not_empty,
	output readout_pkg::fill_t free
);
	import readout_pkg::*;

	word_t mem [bridge_depth];
	logic [$clog2(bridge_depth)-1:0] wr_ptr;
	logic [$clog2(bridge_depth)-1:0] rd_ptr;
	fill_t count;
	logic do_write;
	logic do_read;

	assign do_write = wr_en && (count != fill_t'(bridge_depth));
	assign do_read = pop && not_empty;

	assign not_empty = (count != '0);
	assign free = fill_t'(bridge_depth) - count;
	assign rd_word = mem[rd_ptr]; // head word always visible

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= wr_word;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + fill_t'(do_write) - fill_t'(do_read);
		end
	end

endmodule

//--- serializer/byte_serializer.sv
module byte_serializer (
	input  logic clk,
	input  logic reset,
	input  readout_pkg::word_t rd_word,
	input  logic not_empty,
	output logic pop,
	input  logic tready,
	output readout_pkg::byte_t tdata,
	output logic tvalid,
	output logic tlast
);
	import readout_pkg::*;

	ser_state_t state;
	word_t shift_reg;
	logic [4:0] word_idx; // word within the packet
	logic [3:0] byte_cnt; // bytes left in this word
	logic [3:0] load_bytes;
	logic last_word;
	logic load_now;
	logic byte_done;

	assign last_word = (word_idx == 5'(words_per_packet - 1));

	// header and level words are sent short
	always_comb begin
		if (word_idx == '0) begin
			load_bytes = 4'(header_bytes);
		end else if (last_word) begin
			load_bytes = 4'(level_bytes);
		end else begin
			load_bytes = 4'(slot_bytes);
		end
	end

	assign load_now = (state == load) && not_empty && !pop;
	assign byte_done = (state == shift) && tready; // byte accepted
	assign tdata = shift_reg[word_bits-1 -: 8]; // msb first

	// ========================================
	// byte sequencer
	// ========================================
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= load;
			word_idx <= '0;
			byte_cnt <= '0;
			pop <= 1'b0;
			tvalid <= 1'b0;
			tlast <= 1'b0;
		end else begin
			pop <= 1'b0;
			case (state)
				load: begin
					if (load_now) begin
						pop <= 1'b1;
						byte_cnt <= load_bytes;
						tvalid <= 1'b1;
						tlast <= 1'b0;
						state <= shift;
					end
				end
				shift: begin
					if (tready) begin
						if (byte_cnt == 4'd1) begin
							tvalid <= 1'b0; // next word costs one idle cycle
							tlast <= 1'b0;
							word_idx <= last_word ? '0 : word_idx + 5'd1;
							state <= load;
						end else begin
							byte_cnt <= byte_cnt - 4'd1;
							tlast <= last_word && (byte_cnt == 4'd2);
						end
					end
				end
				default: state <= load;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load_now) begin
			shift_reg <= rd_word;
		end else if (byte_done) begin
			shift_reg <= shift_reg << 8;
		end
	end

endmodule

//--- verilog/readout_control.sv
module readout_control (
	input  logic clk,
	input  logic reset,
	input  readout_pkg::period_t frame_period,
	input  readout_pkg::mac_cfg_t mac_cfg,
	input  readout_pkg::chan_mask_t channel_linked,
	input  readout_pkg::channel_in_t [readout_pkg::num_channels-1:0] channel_in,
	output readout_pkg::chan_mask_t channel_read,
	output readout_pkg::byte_t tdata,
	output logic tvalid,
	input  logic tready,
	output logic tlast
);
	import readout_pkg::*;

	logic frame_open;
	word_t wr_word;
	logic wr_en;
	fill_t fifo_free;
	word_t rd_word;
	logic fifo_not_empty;
	logic pop;

	frame_timer frame_timer_inst (
		.clk(clk),
		.reset(reset),
		.frame_period(frame_period),
		.frame_open(frame_open)
	);

	// ========================================
	// collector into the bridge FIFO
	// ========================================
	packet_builder packet_builder_inst (
		.clk(clk),
		.reset(reset),
		.frame_open(frame_open),
		.fifo_free(fifo_free),
		.mac_cfg(mac_cfg),
		.channel_linked(channel_linked),
		.channel_in(channel_in),
		.channel_read(channel_read),
		.wr_word(wr_word),
		.wr_en(wr_en)
	);

	bridge_fifo bridge_fifo_inst (
		.clk(clk),
		.reset(reset),
		.wr_word(wr_word),
		.wr_en(wr_en),
		.pop(pop),
		.rd_word(rd_word),
		.not_empty(fifo_not_empty),
		.free(fifo_free)
	);

	// byte stream toward the MAC
	byte_serializer byte_serializer_inst (
		.clk(clk),
		.reset(reset),
		.rd_word(rd_word),
		.not_empty(fifo_not_empty),
		.pop(pop),
		.tready(tready),
		.tdata(tdata),
		.tvalid(tvalid),
		.tlast(tlast)
	);

endmodule

//--- test/readout_checker.sv
module readout_checker (
	input  logic clk,
	input  logic reset,
	input  readout_pkg::mac_cfg_t mac_cfg,
	input  readout_pkg::chan_mask_t channel_linked,
	input  readout_pkg::channel_in_t [readout_pkg::num_channels-1:0] channel_in,
	input  readout_pkg::chan_mask_t channel_read,
	input  readout_pkg::byte_t tdata,
	input  logic tvalid,
	input  logic tready,
	input  logic tlast,
	output int mismatch_count,
	output int protocol_count,
	output int frame_count,
	output int hit_count,
	output int log_size
);
	import readout_pkg::*;

	word_t read_log [$]; // hit slot words in read order
	word_t slot_word;
	pkt_count_t exp_count;
	int byte_idx;
	int read_id;
	chan_mask_t scan_mask; // channels still owed a read in this scan
	chan_mask_t exp_read;
	logic hold;
	byte_t hold_data;
	logic hold_last;
	byte_t exp_byte;
	logic exp_last;

	initial begin
		mismatch_count = 0;
		protocol_count = 0;
		frame_count = 0;
		hit_count = 0;
		log_size = 0;
	end

	// expected byte at a position of the frame
	function automatic byte_t expected_byte(input int idx, input pkt_count_t cnt,
			input word_t cur_slot);
		logic [111:0] head;
		logic [79:0] lv;
		int off;
		head = {mac_cfg.dst_mac, mac_cfg.src_mac, cnt, 8'h00};
		for (int i = 0; i < num_channels; i++) begin
			lv[i*level_bits +: level_bits] = channel_in[i].level; // channel 7 on top
		end
		if (idx < header_bytes) begin
			return head[111 - 8*idx -: 8];
		end else if (idx < header_bytes + slots_per_packet*slot_bytes) begin
			off = (idx - header_bytes) % slot_bytes;
			return cur_slot[word_bits - 1 - 8*off -: 8];
		end else begin
			off = idx - header_bytes - slots_per_packet*slot_bytes;
			return lv[79 - 8*off -: 8];
		end
	endfunction

	// ========================================
	// channel reads
	// ========================================
	always @(posedge clk) begin
		if (reset) begin
			read_log.delete();
			scan_mask = '0;
		end else if (channel_read != '0) begin
			// a fresh scan takes every channel that holds data
			if (scan_mask == '0) begin
				for (int i = 0; i < num_channels; i++) begin
					scan_mask[i] = ~channel_in[i].empty;
				end
			end
			exp_read = '0;
			for (int i = num_channels - 1; i >= 0; i--) begin
				if (scan_mask[i] && exp_read == '0) begin
					exp_read[i] = 1'b1; // highest pending channel
				end
			end
			if (channel_read != exp_read) begin
				$display("mismatch at %0t: channel_read expected %b got %b", $time,
					exp_read, channel_read);
				mismatch_count++;
			end
			scan_mask = scan_mask & ~channel_read;
			if ($countones(channel_read) != 1) begin
				$display("at %0t: channel_read %b has more than one bit set", $time,
					channel_read);
				protocol_count++;
			end else begin
				read_id = 0;
				for (int i = 0; i < num_channels; i++) begin
					if (channel_read[i]) begin
						read_id = i;
					end
				end
				if (channel_in[read_id].empty) begin
					$display("at %0t: channel %0d read while its FIFO is empty", $time,
						read_id);
					protocol_count++;
				end
				read_log.push_back({1'b1, chan_id_t'(read_id),
					channel_in[read_id].data[hit_bits-1:0]});
			end
		end else begin
			scan_mask = '0; // a gap in reads ends the scan
		end
		log_size = read_log.size();
	end

	// ========================================
	// byte stream
	// ========================================
	always @(posedge clk) begin
		if (reset) begin
			exp_count = '0;
			byte_idx = 0;
			hold = 1'b0;
			slot_word = '0;
		end else begin
			if (hold) begin
				if (!tvalid) begin
					$display("at %0t: tvalid dropped before the byte was taken", $time);
					protocol_count++;
				end else begin
					if (tdata != hold_data) begin
						$display("mismatch at %0t: tdata held %h now %h", $time, hold_data,
							tdata);
						mismatch_count++;
					end
					if (tlast != hold_last) begin
						$display("mismatch at %0t: tlast held %b now %b", $time, hold_last,
							tlast);
						mismatch_count++;
					end
				end
			end
			if (tvalid && tready) begin
				// slot start picks the hit or empty format
				if (byte_idx >= header_bytes &&
						byte_idx < header_bytes + slots_per_packet*slot_bytes &&
						(byte_idx - header_bytes) % slot_bytes == 0) begin
					if (tdata[7]) begin
						if (read_log.size() == 0) begin
							$display("at %0t: tagged slot sent with no hit read", $time);
							protocol_count++;
							slot_word = '0;
						end else begin
							slot_word = read_log.pop_front();
							hit_count++;
						end
					end else begin
						slot_word = {{(word_bits-16){1'b0}}, status_marker, channel_linked};
					end
				end
				exp_byte = expected_byte(byte_idx, exp_count, slot_word);
				exp_last = (byte_idx == packet_bytes - 1);
				if (tdata != exp_byte) begin
					$display("mismatch at %0t: tdata byte %0d of frame %0d expected %h got %h",
						$time, byte_idx, exp_count, exp_byte, tdata);
					mismatch_count++;
				end
				if (tlast != exp_last) begin
					$display("mismatch at %0t: tlast byte %0d expected %b got %b", $time,
						byte_idx, exp_last, tlast);
					mismatch_count++;
				end
				byte_idx++;
				if (byte_idx == packet_bytes) begin
					byte_idx = 0;
					exp_count = exp_count + pkt_count_t'(1);
					frame_count++;
				end
			end
			hold = tvalid && !tready;
			hold_data = tdata;
			hold_last = tlast;
		end
		log_size = read_log.size();
	end

endmodule

//--- test/tb_readout_control.sv
module tb_readout_control;
	import readout_pkg::*;

	localparam int frames_per_phase = 4;
	// 12 packets and their drain at a quarter tready duty, plus reset gaps
	localparam int cycle_limit = 24 * (packet_bytes * 4 + words_per_packet) + 4000;

	logic clk;
	logic reset;
	period_t frame_period;
	mac_cfg_t mac_cfg;
	chan_mask_t channel_linked;
	channel_in_t [num_channels-1:0] channel_in;
	logic tready;
	chan_mask_t channel_read;
	byte_t tdata;
	logic tvalid;
	logic tlast;

	word_t hit_q [num_channels][$]; // channel FIFO models
	level_t levels [num_channels];
	chan_mask_t took;
	logic [15:0] lfsr_state;
	int cycle_count = 0;
	int tready_mode;
	int hit_odds;
	int push_budget;
	int pushed_total;
	int other_errors;
	int mismatch_count;
	int protocol_count;
	int frame_count;
	int hit_count;
	int log_size;

	readout_control readout_control_inst (
		.clk(clk),
		.reset(reset),
		.frame_period(frame_period),
		.mac_cfg(mac_cfg),
		.channel_linked(channel_linked),
		.channel_in(channel_in),
		.channel_read(channel_read),
		.tdata(tdata),
		.tvalid(tvalid),
		.tready(tready),
		.tlast(tlast)
	);

	readout_checker readout_checker_inst (
		.clk(clk),
		.reset(reset),
		.mac_cfg(mac_cfg),
		.channel_linked(channel_linked),
		.channel_in(channel_in),
		.channel_read(channel_read),
		.tdata(tdata),
		.tvalid(tvalid),
		.tready(tready),
		.tlast(tlast),
		.mismatch_count(mismatch_count),
		.protocol_count(protocol_count),
		.frame_count(frame_count),
		.hit_count(hit_count),
		.log_size(log_size)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		took <= channel_read; // popped at the next falling edge
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, the frames did not complete", cycle_count);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// fibonacci lfsr with taps 16 14 13 11
	function automatic logic [31:0] lfsr_take(input int n);
		logic [31:0] bits;
		logic fb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	task automatic drive_channels();
		for (int i = 0; i < num_channels; i++) begin
			channel_in[i].empty = (hit_q[i].size() == 0);
			channel_in[i].data = (hit_q[i].size() == 0) ? '0 : hit_q[i][0];
			channel_in[i].level = levels[i];
		end
	endtask

	// pops, bursts and tready at one falling edge
	task automatic cycle_step();
		logic [31:0] r0;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		int ch;
		int burst;
		@(negedge clk);
		for (int i = 0; i < num_channels; i++) begin
			if (took[i] && hit_q[i].size() > 0) begin
				void'(hit_q[i].pop_front());
			end
		end
		if (push_budget > 0 && lfsr_take(hit_odds) == (32'd1 << hit_odds) - 32'd1) begin
			ch = int'(lfsr_take(3));
			burst = int'(lfsr_take(2)) + 1;
			for (int b = 0; b < burst; b++) begin
				if (push_budget > 0) begin
					r0 = lfsr_take(30);
					r1 = lfsr_take(30);
					r2 = lfsr_take(30);
					r3 = lfsr_take(30);
					hit_q[ch].push_back({r0[29:0], r1[29:0], r2[29:0], r3[29:0]});
					push_budget--;
					pushed_total++;
				end
			end
		end
		case (tready_mode)
			0: tready = 1'b1;
			1: tready = (lfsr_take(2) == 32'd3); // quarter duty
			default: tready = (lfsr_take(1) != 32'd0);
		endcase
		drive_channels();
	endtask

	function automatic logic models_empty();
		for (int i = 0; i < num_channels; i++) begin
			if (hit_q[i].size() != 0) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	// levels and link mask only change while reset is held
	task automatic run_phase(input int mode, input int odds, input int budget,
			input int level_base, input chan_mask_t linked);
		int start_frames;
		cycle_step();
		reset = 1'b1;
		for (int i = 0; i < num_channels; i++) begin
			levels[i] = level_t'(level_base + i * 37);
		end
		channel_linked = linked;
		tready_mode = mode;
		hit_odds = odds;
		drive_channels();
		cycle_step();
		cycle_step();
		reset = 1'b0;
		start_frames = frame_count;
		push_budget = budget;
		while (frame_count - start_frames < frames_per_phase) begin
			cycle_step();
		end
		push_budget = 0;
		while (!models_empty() || log_size != 0 || took != '0) begin
			cycle_step();
		end
	endtask

	initial begin
		reset = 1'b1;
		frame_period = period_t'(40);
		mac_cfg.dst_mac = 48'h02_11_22_33_44_55;
		mac_cfg.src_mac = 48'h02_AA_BB_CC_DD_EE;
		channel_linked = 8'hFF;
		tready = 1'b0;
		took = '0;
		lfsr_state = 16'd95;
		push_budget = 0;
		pushed_total = 0;
		other_errors = 0;
		tready_mode = 0;
		hit_odds = 3;
		for (int i = 0; i < num_channels; i++) begin
			levels[i] = '0;
		end
		drive_channels();

		// ========================================
		// test phases
		// ========================================
		run_phase(0, 3, 40, 5, 8'hFF); // full rate, moderate hits
		run_phase(1, 2, 60, 300, 8'h5A); // back-pressure, many hits
		run_phase(2, 5, 8, 700, 8'h3C); // sparse hits, mostly empty slots

		if (hit_count != pushed_total) begin
			$display("hits sent %0d differ from hits pushed %0d", hit_count, pushed_total);
			other_errors++;
		end
		$display("errors: %0d mismatch, %0d protocol, %0d other; frames %0d, hits %0d",
			mismatch_count, protocol_count, other_errors, frame_count, hit_count);
		if (mismatch_count + protocol_count + other_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- build.f
common/readout_pkg.sv
verilog/frame_timer.sv
collector/channel_scan.sv
collector/packet_builder.sv
verilog/bridge_fifo.sv
serializer/byte_serializer.sv
verilog/readout_control.sv
test/readout_checker.sv
test/tb_readout_control.sv

//--- run.sh
#!/bin/sh
# build with Verilator and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing -f build.f --top-module tb_readout_control -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "run passed" ||
{ echo "run failed"; exit 1; }
